// ==== include/v16_cfg.svh ====
`ifndef V16_CFG_SVH
`define V16_CFG_SVH

// condition inputs x1..x14.
`define V16_NUM_INPUTS 14

// command outputs y1..y18.
`define V16_NUM_OUTPUTS 18

// state code holds the state number 1..17.
`define V16_STATE_BITS 5
`define V16_ACTION_BITS 4

`endif

// ==== rtl/v16_pkg.sv ====
`include "v16_cfg.svh"

package v16_pkg;

	// x1 sits at bit 0.
	typedef logic [`V16_NUM_INPUTS-1:0] x_t;

	// y1 sits at bit 0.
	typedef logic [`V16_NUM_OUTPUTS-1:0] y_t;

	// encoding is the state number.
	typedef enum logic [`V16_STATE_BITS-1:0] {
		st_s1 = 1,
		st_s2 = 2,
		st_s3 = 3,
		st_s4 = 4,
		st_s5 = 5,
		st_s6 = 6,
		st_s7 = 7,
		st_s8 = 8,
		st_s9 = 9,
		st_s10 = 10,
		st_s11 = 11,
		st_s12 = 12,
		st_s13 = 13,
		st_s14 = 14,
		st_s15 = 15,
		st_s16 = 16,
		st_s17 = 17
	} state_t;

	// output actions of the Mealy table.
	typedef enum logic [`V16_ACTION_BITS-1:0] {
		act_none = 0,
		act_y5,
		act_y679,
		act_y678,
		act_y1234,
		act_y1_2_12_13,
		act_y6_to_11,
		act_y13,
		act_y7_9_14_15,
		act_y16,
		act_y8_9_17,
		act_y18,
		act_y123
	} action_t;

endpackage

// ==== rtl/v16_sequencer.sv ====
`include "v16_cfg.svh"

module v16_sequencer (
	input logic rst,
	input logic clk,
	input v16_pkg::x_t x,
	output v16_pkg::action_t action
);

	localparam int pick_w = `V16_STATE_BITS + `V16_ACTION_BITS;

	logic x1, x2, x3, x4, x5, x6, x7, x8, x9, x10, x11, x12, x13, x14;
	v16_pkg::state_t state_q;
	v16_pkg::state_t state_d;
	logic [pick_w-1:0] nxt;
	logic [pick_w-1:0] ten_pick;
	logic [pick_w-1:0] low_pick;

	// next state and action, packed together.
	function automatic logic [pick_w-1:0] go(input v16_pkg::state_t s,
		input v16_pkg::action_t a);
		return {s, a};
	endfunction

	assign {x14, x13, x12, x11, x10, x9, x8, x7, x6, x5, x4, x3, x2, x1} = x;

	//////////////////////////////////////////////////
	// shared subtrees.

	// x13 high, x11 low, x10 high.
	always_comb
	begin
		if (x14 && x3 && x6)
			ten_pick = go(v16_pkg::st_s4, v16_pkg::act_y5);
		else if (!x14 && x5)
			ten_pick = go(v16_pkg::st_s3, v16_pkg::act_y679);
		else
			ten_pick = go(v16_pkg::st_s5, v16_pkg::act_y678);
	end

	// x13 high, x11 low, as seen from s7 and s14.
	always_comb
	begin
		if (x10)
			low_pick = ten_pick;
		else if (x1)
			low_pick = go(v16_pkg::st_s15, v16_pkg::act_y123);
		else if (x3)
			low_pick = go(v16_pkg::st_s1, v16_pkg::act_none);
		else
			low_pick = go(v16_pkg::st_s5, v16_pkg::act_y678);
	end

	//////////////////////////////////////////////////
	// first-match table per state.

	always_comb
	begin
		case (state_q)
			v16_pkg::st_s1:
				if (!x13)
					nxt = go(v16_pkg::st_s8, v16_pkg::act_y1234);
				else if (x11 && x14)
					nxt = go(v16_pkg::st_s2, v16_pkg::act_y5);
				else if (x11)
					nxt = go(v16_pkg::st_s3, v16_pkg::act_y679);
				else if (x10 && x1)
					nxt = ten_pick;
				else if (x10)
					nxt = go(v16_pkg::st_s8, v16_pkg::act_y1234);
				else if (x14)
					nxt = go(v16_pkg::st_s6, v16_pkg::act_y1_2_12_13);
				else if (x1)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else
					nxt = go(v16_pkg::st_s8, v16_pkg::act_y1234);
			v16_pkg::st_s2:
				if (x11 && x14 && x13 && x1)
					nxt = go(v16_pkg::st_s4, v16_pkg::act_y5);
				else if (x11 && x14 && x13)
					nxt = go(v16_pkg::st_s9, v16_pkg::act_y5);
				else if (!x11 && x10 && x13)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else if (!x2)
					nxt = go(v16_pkg::st_s2, v16_pkg::act_none);
				else if (x4)
					nxt = go(v16_pkg::st_s8, v16_pkg::act_y1234);
				else
					nxt = go(v16_pkg::st_s6, v16_pkg::act_y1_2_12_13);
			v16_pkg::st_s3:
				if (!x13 || x14 || (!x11 && !x10))
					nxt = go(v16_pkg::st_s12, v16_pkg::act_y5);
				else if (x11)
					nxt = go(v16_pkg::st_s10, v16_pkg::act_y13);
				else if (!x2)
					nxt = go(v16_pkg::st_s3, v16_pkg::act_none);
				else if (x6)
					nxt = go(v16_pkg::st_s11, v16_pkg::act_y7_9_14_15);
				else
					nxt = go(v16_pkg::st_s10, v16_pkg::act_y13);
			v16_pkg::st_s4:
				if (x14 && x13 && x11)
					nxt = go(v16_pkg::st_s9, v16_pkg::act_y5);
				else if (x14 && x13 && x10 && x4)
					nxt = go(v16_pkg::st_s13, v16_pkg::act_y16);
				else if (x14 && x13 && x10)
					nxt = go(v16_pkg::st_s4, v16_pkg::act_none);
				else if (x3)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else if (x2)
					nxt = go(v16_pkg::st_s6, v16_pkg::act_y1_2_12_13);
				else
					nxt = go(v16_pkg::st_s4, v16_pkg::act_none);
			v16_pkg::st_s5:
				if (!x13 || (x11 && !x14))
					nxt = go(v16_pkg::st_s4, v16_pkg::act_y5);
				else if (x11 || !x10)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else if (!x4)
					nxt = go(v16_pkg::st_s5, v16_pkg::act_none);
				else if (!x3)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else if (x14)
					nxt = go(v16_pkg::st_s9, v16_pkg::act_y5);
				else
					nxt = go(v16_pkg::st_s6, v16_pkg::act_y1_2_12_13);
			v16_pkg::st_s6:
				if (x11 || !x13 || (x10 == x14))
					nxt = go(v16_pkg::st_s9, v16_pkg::act_y5);
				else if (x10 && !x2)
					nxt = go(v16_pkg::st_s6, v16_pkg::act_none);
				else if (x10 && x6)
					nxt = go(v16_pkg::st_s11, v16_pkg::act_y7_9_14_15);
				else if (x10)
					nxt = go(v16_pkg::st_s10, v16_pkg::act_y13);
				else if (x1)
					nxt = go(v16_pkg::st_s8, v16_pkg::act_y1234);
				else if (x2)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else
					nxt = go(v16_pkg::st_s14, v16_pkg::act_y5);
			v16_pkg::st_s7:
				if (!x13 || (x11 && !x14))
					nxt = go(v16_pkg::st_s2, v16_pkg::act_y5);
				else if (x11 && x8 && !x1)
					nxt = go(v16_pkg::st_s5, v16_pkg::act_y678);
				else if (x11)
					nxt = go(v16_pkg::st_s12, v16_pkg::act_y5);
				else
					nxt = low_pick;
			v16_pkg::st_s8:
				if (x13 && !x10 && !x11 && x2)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else
					nxt = go(v16_pkg::st_s14, v16_pkg::act_y5);
			v16_pkg::st_s9:
				if (x14 && x13 && x11 && x1)
					nxt = go(v16_pkg::st_s14, v16_pkg::act_y5);
				else if (x14 && x13 && x11)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else if (x14 && x13 && x10)
					nxt = go(v16_pkg::st_s13, v16_pkg::act_y16);
				else if (x3)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else if (x6)
					nxt = go(v16_pkg::st_s3, v16_pkg::act_y679);
				else
					nxt = go(v16_pkg::st_s9, v16_pkg::act_none);
			v16_pkg::st_s10:
				if (!x11)
					nxt = go(v16_pkg::st_s13, v16_pkg::act_y16);
				else if (x4)
					nxt = go(v16_pkg::st_s14, v16_pkg::act_y5);
				else
					nxt = go(v16_pkg::st_s11, v16_pkg::act_y7_9_14_15);
			v16_pkg::st_s11:
				if (!x11 && x4)
					nxt = go(v16_pkg::st_s13, v16_pkg::act_y16);
				else if (!x11)
					nxt = go(v16_pkg::st_s11, v16_pkg::act_none);
				else if (!x5 && x4)
					nxt = go(v16_pkg::st_s14, v16_pkg::act_y5);
				else if (!x5)
					nxt = go(v16_pkg::st_s11, v16_pkg::act_y7_9_14_15);
				else if (x6)
					nxt = go(v16_pkg::st_s13, v16_pkg::act_y16);
				else if (x7)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else
					nxt = go(v16_pkg::st_s16, v16_pkg::act_y8_9_17);
			v16_pkg::st_s12:
				if (x11 && x13 && x14 && x5)
					nxt = go(v16_pkg::st_s17, v16_pkg::act_y18);
				else if (x11 && x13 && x14 && x1)
					nxt = go(v16_pkg::st_s14, v16_pkg::act_y5);
				else if ((x11 && x13 && x14) || x3)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else if (x2)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else
					nxt = go(v16_pkg::st_s12, v16_pkg::act_none);
			v16_pkg::st_s13:
				if (x11 && x7)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else
					nxt = go(v16_pkg::st_s16, v16_pkg::act_y8_9_17);
			v16_pkg::st_s14:
				if (!x13 && x3)
					nxt = go(v16_pkg::st_s7, v16_pkg::act_y6_to_11);
				else if (!x13 && (x5 ? x7 : x12))
					nxt = go(v16_pkg::st_s5, v16_pkg::act_y678);
				else if (!x13)
					nxt = go(v16_pkg::st_s14, v16_pkg::act_none);
				else if (x11 && x14)
					nxt = go(v16_pkg::st_s12, v16_pkg::act_y5);
				else if (x11)
					nxt = go(v16_pkg::st_s11, v16_pkg::act_y7_9_14_15);
				else
					nxt = low_pick;
			v16_pkg::st_s15:
				if (x3)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else
					nxt = go(v16_pkg::st_s5, v16_pkg::act_y678);
			v16_pkg::st_s16:
				if (x11)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else if (x4)
					nxt = go(v16_pkg::st_s2, v16_pkg::act_y5);
				else
					nxt = go(v16_pkg::st_s16, v16_pkg::act_none);
			// exit from s17 is fixed, no visit history.
			v16_pkg::st_s17:
				if (x9)
					nxt = go(v16_pkg::st_s13, v16_pkg::act_y16);
				else if (x7)
					nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
				else
					nxt = go(v16_pkg::st_s16, v16_pkg::act_y8_9_17);
			default:
				nxt = go(v16_pkg::st_s1, v16_pkg::act_none);
		endcase
	end

	assign state_d = v16_pkg::state_t'(nxt[pick_w-1:`V16_ACTION_BITS]);
	assign action = v16_pkg::action_t'(nxt[`V16_ACTION_BITS-1:0]);

	//////////////////////////////////////////////////
	// state register.

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state_q <= v16_pkg::st_s1;
		else
			state_q <= state_d;
	end

endmodule

// ==== rtl/v16_action_decode.sv ====
module v16_action_decode (
	input v16_pkg::action_t action,
	output v16_pkg::y_t y
);

	// single command bit, n counts from y1.
	function automatic v16_pkg::y_t yb(input int n);
		return v16_pkg::y_t'(1) << (n - 1);
	endfunction

	always_comb
	begin
		case (action)
			v16_pkg::act_none:
				y = '0;
			v16_pkg::act_y5:
				y = yb(5);
			v16_pkg::act_y679:
				y = yb(6) | yb(7) | yb(9);
			v16_pkg::act_y678:
				y = yb(6) | yb(7) | yb(8);
			v16_pkg::act_y1234:
				y = yb(1) | yb(2) | yb(3) | yb(4);
			v16_pkg::act_y1_2_12_13:
				y = yb(1) | yb(2) | yb(12) | yb(13);
			v16_pkg::act_y6_to_11:
				y = yb(6) | yb(7) | yb(8) | yb(9) | yb(10) | yb(11);
			v16_pkg::act_y13:
				y = yb(13);
			v16_pkg::act_y7_9_14_15:
				y = yb(7) | yb(9) | yb(14) | yb(15);
			v16_pkg::act_y16:
				y = yb(16);
			v16_pkg::act_y8_9_17:
				y = yb(8) | yb(9) | yb(17);
			v16_pkg::act_y18:
				y = yb(18);
			v16_pkg::act_y123:
				y = yb(1) | yb(2) | yb(3);
			// spare codes drive nothing.
			default:
				y = '0;
		endcase
	end

endmodule

// ==== rtl/v16.sv ====
module v16 (
	input logic rst,
	input logic clk,
	input v16_pkg::x_t x,
	output v16_pkg::y_t y
);

	// action of the current cycle.
	v16_pkg::action_t action;

	v16_sequencer seq_i (
		.rst(rst),
		.clk(clk),
		.x(x),
		.action(action)
	);

	// outputs stay combinational from state and x.
	v16_action_decode dec_i (
		.action(action),
		.y(y)
	);

endmodule

// ==== test/v16_clock_gen.sv ====
module v16_clock_gen (
	output logic rst,
	output logic clk
);

	// rst is the clock, clk the active-low reset.
	initial
	begin
		rst = 1'b0;
		clk = 1'b0;
		repeat (5) @(posedge rst);
		clk <= 1'b1;
	end

	always #50 rst = ~rst;

endmodule

// ==== test/v16_asserts.sv ====
module v16_asserts (
	input logic rst,
	input logic clk,
	input v16_pkg::state_t state_q,
	input v16_pkg::action_t action
);

	// only the 17 state codes may appear.
	legal_state: assert property (@(posedge rst) disable iff (!clk)
		state_q >= v16_pkg::st_s1 && state_q <= v16_pkg::st_s17)
		else $error("state register holds an illegal code");

	// y18 is only seen on the way into s17.
	y18_to_s17: assert property (@(posedge rst) disable iff (!clk)
		action == v16_pkg::act_y18 |=> state_q == v16_pkg::st_s17)
		else $error("y18 action was not followed by state s17");

	// first cycle after release.
	start_in_s1: assert property (@(posedge rst)
		$rose(clk) |-> state_q == v16_pkg::st_s1)
		else $error("state after reset release is not s1");

endmodule

bind v16_sequencer v16_asserts asserts_i (
	.rst(rst),
	.clk(clk),
	.state_q(state_q),
	.action(action)
);

// ==== include/v16_tb_cfg.svh ====
`ifndef V16_TB_CFG_SVH
`define V16_TB_CFG_SVH

// random stimulus.
`define V16_TB_SEED 32'ha2805e16
`define V16_TB_RANDOM_CYCLES 2000

// limit for the reset release wait, in clock cycles.
`define V16_TB_RELEASE_LIMIT 20

`endif

// ==== test/v16_tb.sv ====
`include "v16_cfg.svh"
`include "v16_tb_cfg.svh"

module v16_tb;

	localparam int sb = `V16_STATE_BITS;
	localparam int pw = sb + `V16_NUM_OUTPUTS;

	// output patterns with y1 at bit 0.
	localparam v16_pkg::y_t y_none = 18'h00000;
	localparam v16_pkg::y_t y_5 = 18'h00010;
	localparam v16_pkg::y_t y_679 = 18'h00160;
	localparam v16_pkg::y_t y_678 = 18'h000e0;
	localparam v16_pkg::y_t y_1234 = 18'h0000f;
	localparam v16_pkg::y_t y_1_2_12_13 = 18'h01803;
	localparam v16_pkg::y_t y_6_to_11 = 18'h007e0;
	localparam v16_pkg::y_t y_13 = 18'h01000;
	localparam v16_pkg::y_t y_7_9_14_15 = 18'h06140;
	localparam v16_pkg::y_t y_16 = 18'h08000;
	localparam v16_pkg::y_t y_8_9_17 = 18'h10180;
	localparam v16_pkg::y_t y_18 = 18'h20000;
	localparam v16_pkg::y_t y_123 = 18'h00007;

	logic rst;
	logic clk_por;
	logic clk_pulse;
	logic clk;
	v16_pkg::x_t x;
	v16_pkg::y_t y;
	v16_pkg::y_t want_y;
	v16_pkg::state_t model_state = v16_pkg::st_s1;
	v16_pkg::state_t model_next = v16_pkg::st_s1;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int seed = `V16_TB_SEED;

	v16_clock_gen gen_i (
		.rst(rst),
		.clk(clk_por)
	);

	// power-on reset plus pulses from the stimulus.
	assign clk = clk_por & clk_pulse;

	v16 dut_i (
		.rst(rst),
		.clk(clk),
		.x(x),
		.y(y)
	);

	//////////////////////////////////////////////////
	// reference model.

	function automatic logic [pw-1:0] pick(input int s, input v16_pkg::y_t yv);
		return {s[sb-1:0], yv};
	endfunction

	function automatic v16_pkg::x_t x_bit(input int n);
		return v16_pkg::x_t'(1) << (n - 1);
	endfunction

	// x13 high and x11 low as reached from s1, s7 and s14.
	function automatic logic [pw-1:0] low_branch(input v16_pkg::x_t v);
		logic x1, x2, x3, x4, x5, x6, x7, x8, x9, x10, x11, x12, x13, x14;
		{x14, x13, x12, x11, x10, x9, x8, x7, x6, x5, x4, x3, x2, x1} = v;
		if (x10 && x14 && x3 && x6)
			return pick(4, y_5);
		else if (x10 && !x14 && x5)
			return pick(3, y_679);
		else if (x10)
			return pick(5, y_678);
		else if (x1)
			return pick(15, y_123);
		else if (x3)
			return pick(1, y_none);
		return pick(5, y_678);
	endfunction

	function automatic v16_pkg::y_t ref_model(input v16_pkg::state_t s, input v16_pkg::x_t v,
		output v16_pkg::state_t n);
		logic x1, x2, x3, x4, x5, x6, x7, x8, x9, x10, x11, x12, x13, x14;
		logic [pw-1:0] p;
		{x14, x13, x12, x11, x10, x9, x8, x7, x6, x5, x4, x3, x2, x1} = v;
		case (s)
			v16_pkg::st_s1:
				if (!x13)
					p = pick(8, y_1234);
				else if (x11)
					p = x14 ? pick(2, y_5) : pick(3, y_679);
				else if (x10)
					p = x1 ? low_branch(v) : pick(8, y_1234);
				else if (x14)
					p = pick(6, y_1_2_12_13);
				else
					p = x1 ? pick(7, y_6_to_11) : pick(8, y_1234);
			v16_pkg::st_s2:
				if (x11 && x14 && x13)
					p = x1 ? pick(4, y_5) : pick(9, y_5);
				else if (!x11 && x10 && x13)
					p = pick(1, y_none);
				else if (!x2)
					p = pick(2, y_none);
				else
					p = x4 ? pick(8, y_1234) : pick(6, y_1_2_12_13);
			v16_pkg::st_s3:
				if (!x13 || x14 || (!x11 && !x10))
					p = pick(12, y_5);
				else if (x11)
					p = pick(10, y_13);
				else if (!x2)
					p = pick(3, y_none);
				else
					p = x6 ? pick(11, y_7_9_14_15) : pick(10, y_13);
			v16_pkg::st_s4:
				if (x14 && x13 && x11)
					p = pick(9, y_5);
				else if (x14 && x13 && x10)
					p = x4 ? pick(13, y_16) : pick(4, y_none);
				else if (x3)
					p = pick(7, y_6_to_11);
				else
					p = x2 ? pick(6, y_1_2_12_13) : pick(4, y_none);
			v16_pkg::st_s5:
				if (!x13 || (x11 && !x14))
					p = pick(4, y_5);
				else if (x11 || !x10)
					p = pick(1, y_none);
				else if (!x4)
					p = pick(5, y_none);
				else if (!x3)
					p = pick(7, y_6_to_11);
				else
					p = x14 ? pick(9, y_5) : pick(6, y_1_2_12_13);
			v16_pkg::st_s6:
				if (x11 || !x13 || (x10 == x14))
					p = pick(9, y_5);
				else if (x10 && !x2)
					p = pick(6, y_none);
				else if (x10)
					p = x6 ? pick(11, y_7_9_14_15) : pick(10, y_13);
				else if (x1)
					p = pick(8, y_1234);
				else
					p = x2 ? pick(7, y_6_to_11) : pick(14, y_5);
			v16_pkg::st_s7:
				if (!x13 || (x11 && !x14))
					p = pick(2, y_5);
				else if (x11)
					p = (x8 && !x1) ? pick(5, y_678) : pick(12, y_5);
				else
					p = low_branch(v);
			v16_pkg::st_s8:
				p = (x13 && !x10 && !x11 && x2) ? pick(7, y_6_to_11) : pick(14, y_5);
			v16_pkg::st_s9:
				if (x14 && x13 && x11)
					p = x1 ? pick(14, y_5) : pick(7, y_6_to_11);
				else if (x14 && x13 && x10)
					p = pick(13, y_16);
				else if (x3)
					p = pick(7, y_6_to_11);
				else
					p = x6 ? pick(3, y_679) : pick(9, y_none);
			v16_pkg::st_s10:
				if (!x11)
					p = pick(13, y_16);
				else
					p = x4 ? pick(14, y_5) : pick(11, y_7_9_14_15);
			v16_pkg::st_s11:
				if (!x11)
					p = x4 ? pick(13, y_16) : pick(11, y_none);
				else if (!x5)
					p = x4 ? pick(14, y_5) : pick(11, y_7_9_14_15);
				else if (x6)
					p = pick(13, y_16);
				else
					p = x7 ? pick(1, y_none) : pick(16, y_8_9_17);
			v16_pkg::st_s12:
				if (x11 && x13 && x14 && x5)
					p = pick(17, y_18);
				else if (x11 && x13 && x14)
					p = x1 ? pick(14, y_5) : pick(7, y_6_to_11);
				else if (x3)
					p = pick(7, y_6_to_11);
				else
					p = x2 ? pick(1, y_none) : pick(12, y_none);
			v16_pkg::st_s13:
				p = (x11 && x7) ? pick(1, y_none) : pick(16, y_8_9_17);
			v16_pkg::st_s14:
				if (!x13 && x3)
					p = pick(7, y_6_to_11);
				else if (!x13)
					p = (x5 ? x7 : x12) ? pick(5, y_678) : pick(14, y_none);
				else if (x11)
					p = x14 ? pick(12, y_5) : pick(11, y_7_9_14_15);
				else
					p = low_branch(v);
			v16_pkg::st_s15:
				p = x3 ? pick(1, y_none) : pick(5, y_678);
			v16_pkg::st_s16:
				if (x11)
					p = pick(1, y_none);
				else
					p = x4 ? pick(2, y_5) : pick(16, y_none);
			v16_pkg::st_s17:
				if (x9)
					p = pick(13, y_16);
				else
					p = x7 ? pick(1, y_none) : pick(16, y_8_9_17);
			default:
				p = pick(1, y_none);
		endcase
		n = v16_pkg::state_t'(p[pw-1:`V16_NUM_OUTPUTS]);
		return p[`V16_NUM_OUTPUTS-1:0];
	endfunction

	always @(posedge rst or negedge clk)
	begin
		if (!clk)
			model_state <= v16_pkg::st_s1;
		else
			model_state <= model_next;
	end

	//////////////////////////////////////////////////
	// checking.

	task automatic check_y(input v16_pkg::y_t want, input v16_pkg::y_t got, input string what);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("Mismatch at %0t: %s, expected y %h, got %h", $time, what, want, got);
		end
	endtask

	// mid-cycle away from both edges.
	always @(negedge rst)
	begin
		want_y = ref_model(model_state, x, model_next);
		check_y(want_y, y, "reference model");
	end

	//////////////////////////////////////////////////
	// stimulus.

	task automatic drive(input v16_pkg::x_t v);
		@(posedge rst);
		x <= v;
		clk_pulse <= 1'b1;
	endtask

	task automatic apply(input v16_pkg::x_t v, input v16_pkg::y_t want, input string what);
		drive(v);
		@(negedge rst);
		check_y(want, y, what);
	endtask

	// one cycle of reset that the next drive releases.
	task automatic pulse_reset();
		@(posedge rst);
		clk_pulse <= 1'b0;
		x <= '0;
		@(negedge rst);
		check_y(y_1234, y, "s1 rule while reset is pulsed");
	endtask

	task automatic wait_release();
		int n;
		n = 0;
		while (clk_por !== 1'b1)
		begin
			if (n == `V16_TB_RELEASE_LIMIT)
			begin
				$display("Timeout at %0t: power-on reset was never released", $time);
				timeouts++;
				return;
			end
			@(posedge rst);
			n++;
		end
	endtask

	// s1, s2, s9, s14, s12 and into s17.
	task automatic enter_s17();
		v16_pkg::x_t path;
		path = x_bit(11) | x_bit(13) | x_bit(14);
		apply(path, y_5, "s1 to s2");
		apply(path, y_5, "s2 to s9");
		apply(path | x_bit(1), y_5, "s9 to s14");
		apply(path, y_5, "s14 to s12");
		apply(path | x_bit(5), y_18, "s12 into s17");
	endtask

	initial
	begin
		int i;
		x = '0;
		clk_pulse = 1'b1;
		apply('0, y_1234, "s1 rule in reset, x13 low");
		apply(x_bit(11) | x_bit(13) | x_bit(14), y_5, "s1 rule in reset, x11 x13 x14");
		wait_release();

		// eight visits to s17 with no reset between them.
		pulse_reset();
		for (i = 0; i < 8; i++)
		begin
			enter_s17();
			apply(x_bit(9), y_16, "s17 with x9");
			apply(x_bit(11) | x_bit(7), y_none, "s13 rule back to s1");
		end

		pulse_reset();
		enter_s17();
		apply('0, y_8_9_17, "s17 with x9 and x7 low");
		repeat (6) apply(x_bit(3), y_none, "s16 holding");
		apply(x_bit(4), y_5, "s16 with x4");

		pulse_reset();
		enter_s17();
		apply(x_bit(7), y_none, "s17 with x7");
		apply('0, y_1234, "s1 rule after s17");

		for (i = 0; i < `V16_TB_RANDOM_CYCLES; i++)
		begin
			if (i == `V16_TB_RANDOM_CYCLES / 2)
				pulse_reset();
			drive(v16_pkg::x_t'($random(seed)));
		end
		@(posedge rst);

		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== v16.f ====
+incdir+include
rtl/v16_pkg.sv
rtl/v16_sequencer.sv
rtl/v16_action_decode.sv
rtl/v16.sv
test/v16_clock_gen.sv
test/v16_asserts.sv
test/v16_tb.sv

// ==== run_v16.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f v16_sim.log
verilator --binary --timing --assert --top-module v16_tb -Mdir obj_v16 -o v16_sim -f v16.f \
	|| { echo "build failed"; exit 1; }
./obj_v16/v16_sim > v16_sim.log 2>&1
cat v16_sim.log
grep -q "^=== PASS ===$" v16_sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
